// ==== hw/bp_pkg.sv ====
// Shared widths, limits and state encoding for the byte-pipe register memory.
// Referenced by scoped name from the RTL and the testbench.

package bp_pkg;

  // Width of one pipe byte and of one register.
  parameter int BP_DATA_W = 8;

  // Address field of a command byte.
  parameter int BP_ADDR_W = 7;

  // Largest register count the address field can reach.
  parameter int BP_MAX_REG = 1 << BP_ADDR_W;

  // Bit of a command byte that selects a write.
  parameter int BP_CMD_WR_BIT = BP_DATA_W - 1;

  // Command decoder states.
  typedef enum logic [1:0] {
    DEC_CMD   = 2'd0,
    DEC_WDATA = 2'd1
  } bp_dec_state_e;

endpackage

// ==== hw/bp_cmd_decoder.sv ====
// Turns the inbound byte stream into register writes and read requests.
// Holds off read commands while the reply queue is full.

`timescale 1ns/100ps

module bp_cmd_decoder (
  input  logic                            i_clk,
  input  logic                            i_arst_n,
  input  logic                            i_cg,

  // Inbound byte pipe.
  input  logic [bp_pkg::BP_DATA_W-1:0]    i_bp_data,
  input  logic                            i_bp_valid,
  output logic                            o_bp_ready,

  // Reply queue status.
  input  logic                            i_has_space,

  // Register file write port.
  output logic                            o_wr_en,
  output logic [bp_pkg::BP_ADDR_W-1:0]    o_wr_addr,
  output logic [bp_pkg::BP_DATA_W-1:0]    o_wr_data,

  // Register file read address and reply push.
  output logic [bp_pkg::BP_ADDR_W-1:0]    o_rd_addr,
  output logic                            o_push
);

  bp_pkg::bp_dec_state_e           state;
  bp_pkg::bp_dec_state_e           state_nxt;
  logic [bp_pkg::BP_ADDR_W-1:0]    wr_addr_q;
  logic                            accept;
  logic                            in_cmd;
  logic                            is_write;

  assign in_cmd   = (state == bp_pkg::DEC_CMD);
  assign is_write = i_bp_data[bp_pkg::BP_CMD_WR_BIT];

  // A command needs room for a possible reply; write data never does.
  assign o_bp_ready = in_cmd ? (i_has_space & i_cg) : i_cg;
  assign accept     = i_bp_valid & o_bp_ready;

  // Read address is taken straight from the byte on the pipe.
  assign o_rd_addr = i_bp_data[bp_pkg::BP_ADDR_W-1:0];
  assign o_push    = accept & in_cmd & ~is_write;

  assign o_wr_en   = accept & (state == bp_pkg::DEC_WDATA);
  assign o_wr_addr = wr_addr_q;
  assign o_wr_data = i_bp_data;

  always_comb begin
    state_nxt = state;
    case (state)
      bp_pkg::DEC_CMD: begin
        if (accept && is_write) begin
          state_nxt = bp_pkg::DEC_WDATA;
        end
      end
      bp_pkg::DEC_WDATA: begin
        if (accept) begin
          state_nxt = bp_pkg::DEC_CMD;
        end
      end
      default: begin
        state_nxt = bp_pkg::DEC_CMD;
      end
    endcase
  end

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state <= bp_pkg::DEC_CMD;
    end else begin
      state <= state_nxt;
    end
  end

  // Target of a pending write, kept until its data byte arrives.
  always_ff @(posedge i_clk) begin
    if (accept && in_cmd && is_write) begin
      wr_addr_q <= i_bp_data[bp_pkg::BP_ADDR_W-1:0];
    end
  end

  // An offered byte stays on the pipe unchanged until it moves.
  a_in_hold: assert property (
    @(posedge i_clk) disable iff (!i_arst_n)
    (i_bp_valid && !accept) |=> (i_bp_valid && $stable(i_bp_data))
  );

endmodule

// ==== hw/bp_reg_file.sv ====
// Register storage for the byte-pipe register memory.
// Addresses at or above N_REG ignore writes and read back as zero.

`timescale 1ns/100ps

module bp_reg_file #(
  parameter int N_REG = 64
) (
  input  logic                            i_clk,
  input  logic                            i_arst_n,
  input  logic                            i_cg,

  input  logic                            i_wr_en,
  input  logic [bp_pkg::BP_ADDR_W-1:0]    i_wr_addr,
  input  logic [bp_pkg::BP_DATA_W-1:0]    i_wr_data,

  input  logic [bp_pkg::BP_ADDR_W-1:0]    i_rd_addr,
  output logic [bp_pkg::BP_DATA_W-1:0]    o_rd_data
);

  logic [bp_pkg::BP_DATA_W-1:0]    regs [N_REG];
  logic                            wr_ok;
  logic                            rd_ok;

  assign wr_ok = i_cg & i_wr_en & (int'(i_wr_addr) < N_REG);
  assign rd_ok = (int'(i_rd_addr) < N_REG);

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      for (int i = 0; i < N_REG; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_ok) begin
      for (int i = 0; i < N_REG; i++) begin
        if (int'(i_wr_addr) == i) begin
          regs[i] <= i_wr_data;
        end
      end
    end
  end

  // Read mux, zero outside the implemented range.
  always_comb begin
    o_rd_data = '0;
    if (rd_ok) begin
      for (int i = 0; i < N_REG; i++) begin
        if (int'(i_rd_addr) == i) begin
          o_rd_data = regs[i];
        end
      end
    end
  end

  a_n_reg_range: assert property (
    @(posedge i_clk) (N_REG >= 1) && (N_REG <= bp_pkg::BP_MAX_REG)
  );

endmodule

// ==== hw/bp_resp_queue.sv ====
// Two-entry reply FIFO feeding the outbound byte pipe.
// The head entry is presented on o_bp_data while the queue is not empty.

`timescale 1ns/100ps

module bp_resp_queue (
  input  logic                            i_clk,
  input  logic                            i_arst_n,
  input  logic                            i_cg,

  input  logic                            i_push,
  input  logic [bp_pkg::BP_DATA_W-1:0]    i_push_data,
  output logic                            o_has_space,

  // Outbound byte pipe.
  output logic [bp_pkg::BP_DATA_W-1:0]    o_bp_data,
  output logic                            o_bp_valid,
  input  logic                            i_bp_ready
);

  logic [bp_pkg::BP_DATA_W-1:0]    mem [2];
  logic [1:0]                      count;
  logic                            wr_ptr;
  logic                            rd_ptr;
  logic                            do_push;
  logic                            do_pop;

  assign o_has_space = (count < 2'd2);
  assign o_bp_valid  = (count != 2'd0) & i_cg;
  assign o_bp_data   = mem[rd_ptr];

  assign do_push = i_push & i_cg;
  assign do_pop  = o_bp_valid & i_bp_ready;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      count  <= 2'd0;
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
    end else begin
      if (do_push) begin
        wr_ptr <= ~wr_ptr;
      end
      if (do_pop) begin
        rd_ptr <= ~rd_ptr;
      end
      // Push and pop together leave the count alone.
      if (do_push && !do_pop) begin
        count <= count + 2'd1;
      end else if (do_pop && !do_push) begin
        count <= count - 2'd1;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (do_push) begin
      mem[wr_ptr] <= i_push_data;
    end
  end

  // Decoder must only accept a read command when a slot is free.
  a_no_push_full: assert property (
    @(posedge i_clk) disable iff (!i_arst_n)
    i_push |-> (count != 2'd2)
  );

endmodule

// ==== hw/bp_reg_mem.sv ====
// Byte-pipe register memory top level.
// Commands arrive on the inbound pipe, read replies leave on the outbound pipe.

`timescale 1ns/100ps

module bp_reg_mem #(
  parameter int N_REG = 64
) (
  input  logic                            i_clk,
  input  logic                            i_arst_n,
  input  logic                            i_cg,

  input  logic [bp_pkg::BP_DATA_W-1:0]    i_bp_data,
  input  logic                            i_bp_valid,
  output logic                            o_bp_ready,

  output logic [bp_pkg::BP_DATA_W-1:0]    o_bp_data,
  output logic                            o_bp_valid,
  input  logic                            i_bp_ready
);

  logic                            has_space;
  logic                            push;
  logic                            wr_en;
  logic [bp_pkg::BP_ADDR_W-1:0]    wr_addr;
  logic [bp_pkg::BP_DATA_W-1:0]    wr_data;
  logic [bp_pkg::BP_ADDR_W-1:0]    rd_addr;
  logic [bp_pkg::BP_DATA_W-1:0]    rd_data;

  bp_cmd_decoder u_dec (
    .i_clk        (i_clk),
    .i_arst_n     (i_arst_n),
    .i_cg         (i_cg),
    .i_bp_data    (i_bp_data),
    .i_bp_valid   (i_bp_valid),
    .o_bp_ready   (o_bp_ready),
    .i_has_space  (has_space),
    .o_wr_en      (wr_en),
    .o_wr_addr    (wr_addr),
    .o_wr_data    (wr_data),
    .o_rd_addr    (rd_addr),
    .o_push       (push)
  );

  bp_reg_file #(
    .N_REG  (N_REG)
  ) u_regs (
    .i_clk      (i_clk),
    .i_arst_n   (i_arst_n),
    .i_cg       (i_cg),
    .i_wr_en    (wr_en),
    .i_wr_addr  (wr_addr),
    .i_wr_data  (wr_data),
    .i_rd_addr  (rd_addr),
    .o_rd_data  (rd_data)
  );

  // Read data is captured on the edge that accepts the read command.
  bp_resp_queue u_resp (
    .i_clk        (i_clk),
    .i_arst_n     (i_arst_n),
    .i_cg         (i_cg),
    .i_push       (push),
    .i_push_data  (rd_data),
    .o_has_space  (has_space),
    .o_bp_data    (o_bp_data),
    .o_bp_valid   (o_bp_valid),
    .i_bp_ready   (i_bp_ready)
  );

  a_top_n_reg: assert property (
    @(posedge i_clk) (N_REG >= 1) && (N_REG <= bp_pkg::BP_MAX_REG)
  );

endmodule

// ==== sim/tb_bp_reg_mem.sv ====
// Self-checking testbench for the byte-pipe register memory.
// Random commands on the inbound pipe, replies checked against a register model.

`timescale 1ns/100ps

module tb_bp_reg_mem;

  localparam int N_REG       = 5;
  localparam int N_CMDS      = 2000;
  localparam int CLK_NS      = 10;
  localparam int WATCHDOG_NS = N_CMDS * 2 * 40 * CLK_NS;

  logic                            clk;
  logic                            arst_n;
  logic                            cg;
  logic [bp_pkg::BP_DATA_W-1:0]    bp_data_in;
  logic                            bp_valid_in;
  logic                            bp_ready_out;
  logic [bp_pkg::BP_DATA_W-1:0]    bp_data_out;
  logic                            bp_valid_out;
  logic                            bp_ready_in;

  integer seed = 32'h39d0;

  // Register model, pending replies and a copy of the decoder state.
  logic [bp_pkg::BP_DATA_W-1:0]    exp_regs [128];
  logic [bp_pkg::BP_DATA_W-1:0]    exp_q [$];
  bp_pkg::bp_dec_state_e           dec_m;
  int                              wr_addr_m;

  // Bytes waiting to be offered on the inbound pipe.
  logic [bp_pkg::BP_DATA_W-1:0]    tx_q [$];
  logic                            in_moved;
  logic                            lat_pending;
  int                              stall_cnt;
  int                              cmds_sent;
  int                              reads_accepted;
  int                              replies_seen;
  int                              errors;

  bp_reg_mem #(
    .N_REG  (N_REG)
  ) uut (
    .i_clk       (clk),
    .i_arst_n    (arst_n),
    .i_cg        (cg),
    .i_bp_data   (bp_data_in),
    .i_bp_valid  (bp_valid_in),
    .o_bp_ready  (bp_ready_out),
    .o_bp_data   (bp_data_out),
    .o_bp_valid  (bp_valid_out),
    .i_bp_ready  (bp_ready_in)
  );

  always #(CLK_NS / 2) clk = ~clk;

  function automatic int unsigned rand_u(int unsigned n);
    return {$random(seed)} % n;
  endfunction

  // First the reset reads of every register, then random reads and writes.
  task automatic queue_command();
    logic [bp_pkg::BP_ADDR_W-1:0] addr;
    if (cmds_sent < N_REG) begin
      addr = 7'(cmds_sent);
      tx_q.push_back({1'b0, addr});
    end else begin
      if (rand_u(8) == 0) begin
        addr = 7'(rand_u(128));
      end else begin
        addr = 7'(rand_u(8));
      end
      if (rand_u(2) == 0) begin
        tx_q.push_back({1'b0, addr});
      end else begin
        tx_q.push_back({1'b1, addr});
        tx_q.push_back(8'(rand_u(256)));
      end
    end
    cmds_sent++;
  endtask

  task automatic drive_cycle();
    cg = (rand_u(100) != 0);
    // Occasional long stalls fill the reply queue.
    if (stall_cnt > 0) begin
      bp_ready_in = 1'b0;
      stall_cnt--;
    end else if (rand_u(60) == 0) begin
      stall_cnt   = 40;
      bp_ready_in = 1'b0;
    end else begin
      bp_ready_in = (rand_u(6) != 0);
    end
    if (in_moved) begin
      bp_valid_in = 1'b0;
      in_moved    = 1'b0;
    end
    if (!bp_valid_in) begin
      if (tx_q.size() == 0 && cmds_sent < N_CMDS) begin
        queue_command();
      end
      if (tx_q.size() != 0 && rand_u(3) == 0) begin
        bp_data_in  = tx_q.pop_front();
        bp_valid_in = 1'b1;
      end
    end
  endtask

  // Checks one cycle from values sampled just before the rising edge.
  task automatic check_cycle();
    logic [bp_pkg::BP_DATA_W-1:0] exp_data;
    logic                         exp_ready;
    logic                         exp_valid;
    int                           addr;
    exp_valid = (exp_q.size() != 0) && cg;
    if (dec_m == bp_pkg::DEC_CMD) begin
      exp_ready = cg && (exp_q.size() < 2);
    end else begin
      exp_ready = cg;
    end
    if (!cg && (bp_ready_out || bp_valid_out)) begin
      errors++;
      $display("Clock gate is low but a pipe ready or valid output is high");
    end
    if (bp_ready_out !== exp_ready) begin
      errors++;
      $display("FAIL o_bp_ready: expected 0x%0h got 0x%0h", exp_ready, bp_ready_out);
    end
    if (bp_valid_out !== exp_valid) begin
      errors++;
      $display("FAIL o_bp_valid: expected 0x%0h got 0x%0h", exp_valid, bp_valid_out);
    end
    if (lat_pending && cg && !bp_valid_out) begin
      errors++;
      $display("Reply valid did not rise one cycle after a read into an empty queue");
    end
    lat_pending = 1'b0;
    if (bp_valid_out && bp_ready_in && cg) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("A reply byte left the design with no read outstanding");
      end else begin
        exp_data = exp_q.pop_front();
        if (bp_data_out !== exp_data) begin
          errors++;
          $display("FAIL o_bp_data: expected 0x%02h got 0x%02h", exp_data, bp_data_out);
        end
      end
      replies_seen++;
    end
    if (bp_valid_in && bp_ready_out && cg) begin
      in_moved = 1'b1;
      addr     = int'(bp_data_in[bp_pkg::BP_ADDR_W-1:0]);
      if (dec_m == bp_pkg::DEC_CMD) begin
        if (bp_data_in[bp_pkg::BP_DATA_W-1]) begin
          wr_addr_m = addr;
          dec_m     = bp_pkg::DEC_WDATA;
        end else begin
          if (exp_q.size() >= 2) begin
            errors++;
            $display("A read was accepted while two replies were already waiting");
          end
          if (exp_q.size() == 0) begin
            lat_pending = 1'b1;
          end
          // Unimplemented registers always read back as zero.
          exp_q.push_back((addr < N_REG) ? exp_regs[addr] : 8'h00);
          reads_accepted++;
        end
      end else begin
        if (wr_addr_m < N_REG) begin
          exp_regs[wr_addr_m] = bp_data_in;
        end
        dec_m = bp_pkg::DEC_CMD;
      end
    end
  endtask

  function automatic logic all_done();
    return (cmds_sent == N_CMDS) && (tx_q.size() == 0) && !bp_valid_in &&
           (exp_q.size() == 0) && (dec_m == bp_pkg::DEC_CMD);
  endfunction

  always begin
    @(negedge clk);
    #4;
    if (arst_n) begin
      check_cycle();
    end
  end

  initial begin
    clk            = 1'b0;
    arst_n         = 1'b0;
    cg             = 1'b1;
    bp_data_in     = '0;
    bp_valid_in    = 1'b0;
    bp_ready_in    = 1'b0;
    dec_m          = bp_pkg::DEC_CMD;
    wr_addr_m      = 0;
    in_moved       = 1'b0;
    lat_pending    = 1'b0;
    stall_cnt      = 0;
    cmds_sent      = 0;
    reads_accepted = 0;
    replies_seen   = 0;
    errors         = 0;
    for (int i = 0; i < 128; i++) begin
      exp_regs[i] = 8'h00;
    end
    repeat (10) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    while (!all_done()) begin
      @(negedge clk);
      drive_cycle();
    end
    repeat (3) @(negedge clk);
    if (replies_seen != reads_accepted) begin
      errors++;
      $display("Reply count does not match the number of accepted reads");
    end
    $display("Errors: %0d, reads accepted: %0d, replies seen: %0d",
             errors, reads_accepted, replies_seen);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // Generous bound of 40 cycles per byte and two bytes per command.
  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired before all commands and replies completed");
    $display("Simulation failed");
    $finish;
  end

endmodule

// ==== flist.f ====
hw/bp_pkg.sv
hw/bp_cmd_decoder.sv
hw/bp_reg_file.sv
hw/bp_resp_queue.sv
hw/bp_reg_mem.sv
sim/tb_bp_reg_mem.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the byte-pipe register memory testbench with Verilator and runs it.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_bp_reg_mem \
  -Mdir obj_dir \
  -f flist.f

out=$(./obj_dir/Vtb_bp_reg_mem)
echo "$out"

if echo "$out" | grep -q "^Simulation passed$"; then
  exit 0
fi
exit 1
